// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;
	localparam int num_regs = 32;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;

	localparam word_t reset_pc = '0;

	// funct3 codes of the supported subset
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_word = 3'b010;
	localparam logic [2:0] f3_beq = 3'b000;

	typedef enum logic [6:0] {
		opc_op = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_load = 7'b0000011,
		opc_store = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal = 7'b1101111
	} opcode_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_t;

	// one instruction word seen through several field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_addr_t rs2;
			reg_addr_t rs1;
			logic [2:0] funct3;
			reg_addr_t rd;
			opcode_t opcode;
		} r_type;
		struct packed {
			logic [11:0] imm;
			reg_addr_t rs1;
			logic [2:0] funct3;
			reg_addr_t rd;
			opcode_t opcode;
		} i_type;
		struct packed {
			logic [6:0] imm_hi;
			reg_addr_t rs2;
			reg_addr_t rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			opcode_t opcode;
		} s_type;
		// scattered immediate bits shared by beq and jal
		struct packed {
			logic sign;
			logic [5:0] imm_30_25;
			logic [3:0] imm_24_21;
			logic bit_20;
			logic [7:0] imm_19_12;
			logic [3:0] imm_11_8;
			logic bit_7;
			opcode_t opcode;
		} b_j_type;
	} instr_t;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic alu_src_imm;
		logic branch;
		logic jump;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		instr_t instr;
	} ifid_t;

	typedef struct packed {
		word_t pc;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t rdata1;
		word_t rdata2;
		word_t imm;
		ctrl_t ctrl;
	} idex_t;

	typedef struct packed {
		word_t alu_result;
		word_t store_data;
		reg_addr_t rd;
		ctrl_t ctrl;
	} exmem_t;

	typedef struct packed {
		word_t alu_result;
		word_t load_data;
		reg_addr_t rd;
		logic reg_write;
		logic mem_to_reg;
	} memwb_t;

	typedef struct packed {
		logic reg_write;
		reg_addr_t rd;
		word_t value;
	} fwd_t;

endpackage

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
	input wire clock,
	input wire reset,
	input wire rv_pkg::reg_addr_t rs1,
	input wire rv_pkg::reg_addr_t rs2,
	input wire rv_pkg::fwd_t wb,
	output rv_pkg::word_t rdata1,
	output rv_pkg::word_t rdata2
);
	import rv_pkg::*;

	word_t regs [num_regs];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			regs <= '{default: '0};
		end else if (wb.reg_write && wb.rd != '0) begin
			regs[wb.rd] <= wb.value;
		end
	end

	// x0 reads zero and a same-cycle write goes straight through
	assign rdata1 = (rs1 == '0) ? '0 :
		(wb.reg_write && wb.rd == rs1) ? wb.value : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 :
		(wb.reg_write && wb.rd == rs2) ? wb.value : regs[rs2];

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
	input wire clock,
	input wire reset,
	input wire stall,
	input wire flush,
	input wire freeze,
	input wire redirect,
	input wire rv_pkg::word_t target_pc,
	input wire rv_pkg::instr_t instr,
	output rv_pkg::word_t pc,
	output rv_pkg::ifid_t ifid
);
	import rv_pkg::*;

	// program counter
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else if (!freeze) begin
			// a taken transfer wins over the load-use hold
			if (redirect) begin
				pc <= target_pc;
			end else if (!stall) begin
				pc <= pc + word_t'(4);
			end
		end
	end

	// fetch to decode register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ifid <= '0;
		end else if (!freeze) begin
			if (flush) begin
				// all-zero word decodes as a bubble
				ifid <= '0;
			end else if (!stall) begin
				ifid.pc <= pc;
				ifid.instr <= instr;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input wire clock,
	input wire reset,
	input wire flush,
	input wire stall,
	input wire freeze,
	input wire rv_pkg::ifid_t ifid,
	input wire rv_pkg::fwd_t wb,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	output rv_pkg::idex_t idex
);
	import rv_pkg::*;

	instr_t ir;
	ctrl_t ctrl;
	word_t imm;
	word_t rdata1;
	word_t rdata2;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_j;

	assign ir = ifid.instr;
	assign rs1 = ir.r_type.rs1;
	assign rs2 = ir.r_type.rs2;

	register_file register_file_i (
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.wb(wb),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	// immediates per format
	assign imm_i = {{20{ir.i_type.imm[11]}}, ir.i_type.imm};
	assign imm_s = {{20{ir.s_type.imm_hi[6]}}, ir.s_type.imm_hi, ir.s_type.imm_lo};
	assign imm_b = {{20{ir.b_j_type.sign}}, ir.b_j_type.bit_7, ir.b_j_type.imm_30_25,
		ir.b_j_type.imm_11_8, 1'b0};
	assign imm_j = {{12{ir.b_j_type.sign}}, ir.b_j_type.imm_19_12, ir.b_j_type.bit_20,
		ir.b_j_type.imm_30_25, ir.b_j_type.imm_24_21, 1'b0};

	// main control with anything unsupported left as a bubble
	always_comb begin
		ctrl = '0;
		imm = '0;
		case (ir.r_type.opcode)
			opc_op: begin
				ctrl.reg_write = 1'b1;
				case (ir.r_type.funct3)
					f3_add_sub: ctrl.alu_op = ir.r_type.funct7[5] ? alu_sub : alu_add;
					f3_slt: ctrl.alu_op = alu_slt;
					f3_xor: ctrl.alu_op = alu_xor;
					f3_or: ctrl.alu_op = alu_or;
					f3_and: ctrl.alu_op = alu_and;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			opc_op_imm: begin
				ctrl.reg_write = (ir.i_type.funct3 == f3_add_sub);
				ctrl.alu_src_imm = 1'b1;
				imm = imm_i;
			end
			opc_load: begin
				ctrl.reg_write = (ir.i_type.funct3 == f3_word);
				ctrl.mem_read = (ir.i_type.funct3 == f3_word);
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = imm_i;
			end
			opc_store: begin
				ctrl.mem_write = (ir.s_type.funct3 == f3_word);
				ctrl.alu_src_imm = 1'b1;
				imm = imm_s;
			end
			opc_branch: begin
				ctrl.branch = (ir.r_type.funct3 == f3_beq);
				imm = imm_b;
			end
			opc_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump = 1'b1;
				imm = imm_j;
			end
			default: ctrl = '0;
		endcase
	end

	// decode to execute register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			idex <= '0;
		end else if (!freeze) begin
			if (flush || stall) begin
				idex <= '0;
			end else begin
				idex.pc <= ifid.pc;
				idex.rs1 <= rs1;
				idex.rs2 <= rs2;
				idex.rd <= ir.r_type.rd;
				idex.rdata1 <= rdata1;
				idex.rdata2 <= rdata2;
				idex.imm <= imm;
				idex.ctrl <= ctrl;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	input wire rv_pkg::reg_addr_t rs1,
	input wire rv_pkg::reg_addr_t rs2,
	input wire rv_pkg::idex_t idex,
	input wire redirect,
	input wire ren,
	input wire wen,
	input wire mem_ready,
	output logic stall,
	output logic flush,
	output logic freeze
);

	logic load_use;

	// load in execute feeding the instruction in decode
	assign load_use = idex.ctrl.mem_read && idex.rd != '0 &&
		(idex.rd == rs1 || idex.rd == rs2);

	// data access still waiting for the memory
	assign freeze = (ren || wen) && !mem_ready;

	// freeze holds everything, so it masks the other two
	assign stall = load_use && !freeze;
	assign flush = redirect && !freeze;

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input wire clock,
	input wire reset,
	input wire freeze,
	input wire rv_pkg::idex_t idex,
	input wire rv_pkg::fwd_t exm,
	input wire rv_pkg::fwd_t wb,
	output logic redirect,
	output rv_pkg::word_t target_pc,
	output rv_pkg::exmem_t exmem
);
	import rv_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t alu_b;
	word_t alu_out;

	// newest producer first and x0 never forwards
	function automatic word_t forward(reg_addr_t src, word_t reg_value, fwd_t mem_src,
		fwd_t wb_src);
		if (mem_src.reg_write && mem_src.rd != '0 && mem_src.rd == src) begin
			return mem_src.value;
		end
		if (wb_src.reg_write && wb_src.rd != '0 && wb_src.rd == src) begin
			return wb_src.value;
		end
		return reg_value;
	endfunction

	assign op_a = forward(idex.rs1, idex.rdata1, exm, wb);
	assign op_b = forward(idex.rs2, idex.rdata2, exm, wb);
	assign alu_b = idex.ctrl.alu_src_imm ? idex.imm : op_b;

	always_comb begin
		case (idex.ctrl.alu_op)
			alu_add: alu_out = op_a + alu_b;
			alu_sub: alu_out = op_a - alu_b;
			alu_and: alu_out = op_a & alu_b;
			alu_or: alu_out = op_a | alu_b;
			alu_xor: alu_out = op_a ^ alu_b;
			alu_slt: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
			default: alu_out = '0;
		endcase
	end

	// beq and jal both resolve here
	assign target_pc = idex.pc + idex.imm;
	assign redirect = idex.ctrl.jump || (idex.ctrl.branch && op_a == op_b);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			exmem <= '0;
		end else if (!freeze) begin
			// jal links the return address
			exmem.alu_result <= idex.ctrl.jump ? idex.pc + word_t'(4) : alu_out;
			exmem.store_data <= op_b;
			exmem.rd <= idex.rd;
			exmem.ctrl <= idex.ctrl;
		end
	end

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
	input wire clock,
	input wire reset,
	input wire freeze,
	input wire rv_pkg::exmem_t exmem,
	input wire rv_pkg::word_t data_read,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_write,
	output logic ren,
	output logic wen,
	output rv_pkg::fwd_t exm,
	output rv_pkg::fwd_t wb
);
	import rv_pkg::*;

	memwb_t memwb;

	// request stays up while exmem is held by freeze
	assign data_addr = exmem.alu_result;
	assign data_write = exmem.store_data;
	assign ren = exmem.ctrl.mem_read;
	assign wen = exmem.ctrl.mem_write;

	assign exm.reg_write = exmem.ctrl.reg_write;
	assign exm.rd = exmem.rd;
	assign exm.value = exmem.alu_result;

	// load data is taken at the edge that completes the access
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			memwb <= '0;
		end else if (!freeze) begin
			memwb.alu_result <= exmem.alu_result;
			memwb.load_data <= data_read;
			memwb.rd <= exmem.rd;
			memwb.reg_write <= exmem.ctrl.reg_write;
			memwb.mem_to_reg <= exmem.ctrl.mem_to_reg;
		end
	end

	// writeback value
	assign wb.reg_write = memwb.reg_write;
	assign wb.rd = memwb.rd;
	assign wb.value = memwb.mem_to_reg ? memwb.load_data : memwb.alu_result;

endmodule

`default_nettype wire

// ==== source/cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
	input wire clock,
	input wire reset,
	output rv_pkg::word_t pc,
	input wire rv_pkg::instr_t instr,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_write,
	output logic ren,
	output logic wen,
	input wire rv_pkg::word_t data_read,
	input wire mem_ready
);
	import rv_pkg::*;

	ifid_t ifid;
	idex_t idex;
	exmem_t exmem;
	fwd_t exm_fwd;
	fwd_t wb_fwd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t target_pc;
	logic redirect;
	logic stall;
	logic flush;
	logic freeze;

	fetch_stage fetch_stage_i (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.freeze(freeze),
		.redirect(redirect),
		.target_pc(target_pc),
		.instr(instr),
		.pc(pc),
		.ifid(ifid)
	);

	decode_stage decode_stage_i (
		.clock(clock),
		.reset(reset),
		.flush(flush),
		.stall(stall),
		.freeze(freeze),
		.ifid(ifid),
		.wb(wb_fwd),
		.rs1(rs1),
		.rs2(rs2),
		.idex(idex)
	);

	execute_stage execute_stage_i (
		.clock(clock),
		.reset(reset),
		.freeze(freeze),
		.idex(idex),
		.exm(exm_fwd),
		.wb(wb_fwd),
		.redirect(redirect),
		.target_pc(target_pc),
		.exmem(exmem)
	);

	memory_stage memory_stage_i (
		.clock(clock),
		.reset(reset),
		.freeze(freeze),
		.exmem(exmem),
		.data_read(data_read),
		.data_addr(data_addr),
		.data_write(data_write),
		.ren(ren),
		.wen(wen),
		.exm(exm_fwd),
		.wb(wb_fwd)
	);

	hazard_unit hazard_unit_i (
		.rs1(rs1),
		.rs2(rs2),
		.idex(idex),
		.redirect(redirect),
		.ren(ren),
		.wen(wen),
		.mem_ready(mem_ready),
		.stall(stall),
		.flush(flush),
		.freeze(freeze)
	);

endmodule

`default_nettype wire

// ==== tests/cpu_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core_tb;
	import rv_pkg::*;

	localparam int prog_base = 'h10;
	localparam int expect_base = 'h80;
	localparam int ram_words = 256;
	localparam int reset_cycles = 16;
	localparam int drain_cycles = 8;

	logic clock = 1'b0;
	logic reset;
	word_t pc;
	instr_t instr;
	word_t data_addr;
	word_t data_write;
	logic ren;
	logic wen;
	word_t data_read;
	logic mem_ready;

	word_t stim [256];
	word_t ram [ram_words];
	int prog_len;
	int num_stores;
	int store_count;
	int cycle_count;
	int cycle_limit;
	int wait_left;
	int ram_index;
	logic busy;
	integer seed = 32'h33de_bfa5;

	cpu_core cpu_core_i (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.data_addr(data_addr),
		.data_write(data_write),
		.ren(ren),
		.wen(wen),
		.data_read(data_read),
		.mem_ready(mem_ready)
	);

	initial begin
		forever #2 clock = ~clock;
	end

	task automatic end_with_failure();
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(string name, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
			end_with_failure();
		end
	endtask

	// words past the program read as a nop
	function automatic instr_t rom_word(word_t addr);
		word_t index;
		index = addr >> 2;
		if (index < word_t'(prog_len)) begin
			return instr_t'(stim[prog_base + int'(index)]);
		end
		return instr_t'(32'h0000_0013);
	endfunction

	// rom and data ram answered from the falling edge
	always @(negedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles with %0d of %0d stores seen",
				cycle_count, store_count, num_stores);
			end_with_failure();
		end
		instr = rom_word(pc);
		mem_ready = 1'b0;
		if (ren || wen) begin
			if (data_addr[31:10] != '0) begin
				$display("data access at %08h is outside the data ram", data_addr);
				end_with_failure();
			end
			// pick the latency of a new request
			if (!busy) begin
				busy = 1'b1;
				wait_left = int'($unsigned($random(seed)) % 4);
			end
			if (wait_left == 0) begin
				busy = 1'b0;
				mem_ready = 1'b1;
				ram_index = int'(data_addr[9:2]);
				if (ren) begin
					data_read = ram[ram_index];
				end
				if (wen) begin
					if (store_count >= num_stores) begin
						$display("unexpected extra store of %08h to %08h",
							data_write, data_addr);
						end_with_failure();
					end
					check_value($sformatf("store %0d address", store_count),
						stim[expect_base + 2 * store_count], data_addr);
					check_value($sformatf("store %0d value", store_count),
						stim[expect_base + 2 * store_count + 1], data_write);
					ram[ram_index] = data_write;
					store_count++;
				end
			end else begin
				wait_left--;
			end
		end
	end

	initial begin
		int i;
		reset = 1'b0;
		instr = '0;
		data_read = '0;
		mem_ready = 1'b0;
		busy = 1'b0;
		wait_left = 0;
		store_count = 0;
		cycle_count = 0;
		$readmemh("tests/cpu_stimulus.txt", stim);
		prog_len = int'(stim[0]);
		num_stores = int'(stim[1]);
		cycle_limit = 50 * prog_len;
		// fill so a stray load never reads a plausible result
		for (i = 0; i < ram_words; i++) begin
			ram[i] = 32'h5a00_0000 | word_t'(i << 8) | word_t'(255 - i);
		end

		repeat (reset_cycles) begin
			@(negedge clock);
			check_value("pc during reset", reset_pc, pc);
			check_value("ren during reset", '0, word_t'(ren));
			check_value("wen during reset", '0, word_t'(wen));
		end
		reset = 1'b1;

		// pipeline still empty one cycle after release
		@(negedge clock);
		check_value("ren after reset", '0, word_t'(ren));
		check_value("wen after reset", '0, word_t'(wen));

		wait (store_count == num_stores);
		// late or repeated stores would show up here
		repeat (drain_cycles) @(negedge clock);
		// the halt loop leaves the data port idle
		check_value("ren after the program", '0, word_t'(ren));
		check_value("wen after the program", '0, word_t'(wen));
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
source/rv_pkg.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_core.sv
tests/cpu_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the cpu core testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f compile.f --top-module cpu_core_tb \
	-Mdir "$build_dir" -o cpu_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"$build_dir/cpu_core_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "All tests passed" "$log_file"; then
	exit 0
fi
echo "pass message not found in $log_file"
exit 1

// ==== tests/cpu_stimulus.txt ====
// words 00-01: program length in words, number of expected stores
// words 10 on: program; words 80 on: expected stores, byte address then value
@00
00000025 0000000c
@10
00c00093 00500113 // addi x1,x0,12 ; addi x2,x0,5
002081b3 10302023 // add x3,x1,x2 ; sw x3,0x100(x0)
40208233 10402223 // sub x4,x1,x2 ; sw x4,0x104(x0)
0020f2b3 10502423 // and x5,x1,x2 ; sw x5,0x108(x0)
0020e333 10602623 // or x6,x1,x2 ; sw x6,0x10c(x0)
0020c3b3 10702823 // xor x7,x1,x2 ; sw x7,0x110(x0)
ffd00493 0014a433 // addi x9,x0,-3 ; slt x8,x9,x1
10802a23 10902c23 // sw x8,0x114(x0) ; sw x9,0x118(x0)
06400513 00150513 // addi x10,x0,100 ; addi x10,x10,1
00a505b3 10b02e23 // add x11,x10,x10 ; sw x11,0x11c(x0)
10002603 02860693 // lw x12,0x100(x0) ; addi x13,x12,40
12d02023 05500713 // sw x13,0x120(x0) ; addi x14,x0,0x55 (marker)
00108663 12e02223 // beq x1,x1,+12 ; sw x14,0x124(x0) squashed
12e02423 02100793 // sw x14,0x128(x0) squashed ; addi x15,x0,33
12f02623 00208663 // sw x15,0x12c(x0) ; beq x1,x2,+12 not taken
02c00813 13002823 // addi x16,x0,44 ; sw x16,0x130(x0)
00c008ef 12e02a23 // jal x17,+12 ; sw x14,0x134(x0) squashed
12e02c23 13102e23 // sw x14,0x138(x0) squashed ; sw x17,0x13c(x0)
0000006f          // jal x0,0 halt loop
@80
00000100 00000011
00000104 00000007
00000108 00000004
0000010c 0000000d
00000110 00000009
00000114 00000001
00000118 fffffffd
0000011c 000000ca
00000120 00000039
0000012c 00000021
00000130 0000002c
0000013c 00000084
